//--- hdl/fpu_seq_pkg.sv
package fpu_seq_pkg;

    // --------------------
    // Sizes
    localparam int ADDR_W      = 12;   // Microcode address width
    localparam int ROM_DEPTH   = 4096; // Words in microcode ROM
    localparam int PROG_IDX_W  = 4;    // Entry table index width
    localparam int STACK_DEPTH = 16;   // Return slots
    localparam int NEXT_W      = 15;   // Next-address field, low ADDR_W bits used

    // --------------------
    // Fixed microcode addresses
    localparam logic [ADDR_W-1:0] ADDR_HALT       = 12'h000; // Default word, also RET on empty
    localparam logic [ADDR_W-1:0] ADDR_OPND_SUB   = 12'h010; // Load A, load B, return
    localparam logic [ADDR_W-1:0] ADDR_ARITH_TAIL = 12'h020; // Load result, store, halt
    localparam logic [ADDR_W-1:0] ADDR_FADD       = 12'h100;
    localparam logic [ADDR_W-1:0] ADDR_FSUB       = 12'h110;
    localparam logic [ADDR_W-1:0] ADDR_FMUL       = 12'h120;
    localparam logic [ADDR_W-1:0] ADDR_FDIV       = 12'h130;
    localparam logic [ADDR_W-1:0] ADDR_FCOM       = 12'h140;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_FETCH  = 3'd1,
        ST_DECODE = 3'd2,
        ST_EXEC   = 3'd3
    } seq_state_e;

    // Top-level opcodes
    typedef enum logic [3:0] {
        OP_EXEC = 4'h1, // Run a micro-op
        OP_JUMP = 4'h2,
        OP_CALL = 4'h3, // Push pc+1, jump
        OP_RET  = 4'h4,
        OP_HALT = 4'hF
    } opcode_e;

    // Micro-ops under OP_EXEC
    typedef enum logic [4:0] {
        MOP_LOAD_A         = 5'h01, // Wait for data bus, operand A
        MOP_STORE          = 5'h02,
        MOP_LOAD_B         = 5'h05, // Wait for data bus, operand B
        MOP_CALL_ARITH     = 5'h10, // Imm holds arith op
        MOP_WAIT_ARITH     = 5'h11,
        MOP_LOAD_ARITH_RES = 5'h12,
        MOP_SET_STATUS     = 5'h17,
        MOP_GET_STATUS     = 5'h18,
        MOP_GET_CC         = 5'h19
    } micro_op_e;

    // 32-bit microinstruction word
    typedef struct packed {
        opcode_e           opcode;    // [31:28]
        micro_op_e         micro_op;  // [27:23]
        logic [7:0]        imm;       // [22:15]
        logic [NEXT_W-1:0] next_addr; // [14:0]
    } microinstr_t;

endpackage

//--- hdl/fpu_bus_pkg.sv
package fpu_bus_pkg;

    localparam int FP_W     = 80; // Extended precision word
    localparam int STATUS_W = 16;

    typedef logic [FP_W-1:0] fp_word_t;

    // Arithmetic unit operations
    typedef enum logic [4:0] {
        AR_ADD = 5'd0,
        AR_SUB = 5'd1,
        AR_MUL = 5'd2,
        AR_DIV = 5'd3,
        AR_CMP = 5'd4
    } arith_op_e;

    // --------------------
    // Condition codes, less lands in bit 0 of the packed word
    typedef struct packed {
        logic unordered; // [3]
        logic greater;   // [2]
        logic equal;     // [1]
        logic less;      // [0]
    } cond_codes_t;

    // Request to arithmetic unit, valid is a one-cycle pulse
    typedef struct packed {
        logic      valid;
        arith_op_e op;
        fp_word_t  a;
        fp_word_t  b;
    } arith_req_t;

    // Response, result and cc held after done
    typedef struct packed {
        logic        done;
        fp_word_t    result;
        cond_codes_t cc;
    } arith_rsp_t;

endpackage

//--- hdl/micro_rom.sv
`timescale 1ns/1ps

module micro_rom
    import fpu_seq_pkg::*;
    import fpu_bus_pkg::*;
(
    input  logic                  clk,
    input  logic [ADDR_W-1:0]     rom_addr,
    output microinstr_t           instr,      // One cycle after rom_addr
    input  logic [PROG_IDX_W-1:0] entry_idx,
    output logic [ADDR_W-1:0]     entry_addr  // Combinational lookup
);

    microinstr_t rom [ROM_DEPTH];

    // EXEC word builder
    function automatic microinstr_t uop(micro_op_e mop, logic [7:0] imm, int nxt);
        microinstr_t w;
        w.opcode    = OP_EXEC;
        w.micro_op  = mop;
        w.imm       = imm;
        w.next_addr = NEXT_W'(nxt);
        return w;
    endfunction

    // Control word builder, micro-op field ignored
    function automatic microinstr_t ctl(opcode_e opc, int nxt);
        microinstr_t w;
        w.opcode    = opc;
        w.micro_op  = micro_op_e'(5'd0);
        w.imm       = 8'd0;
        w.next_addr = NEXT_W'(nxt);
        return w;
    endfunction

    // Two-operand arithmetic program sharing the operand sub and the tail
    task automatic put_arith_prog(input int base, input arith_op_e aop);
        rom[base]     = ctl(OP_CALL, ADDR_OPND_SUB);              // Returns to base+1
        rom[base + 1] = uop(MOP_CALL_ARITH, 8'(aop), base + 2);
        rom[base + 2] = uop(MOP_WAIT_ARITH, 8'd0, base + 3);
        rom[base + 3] = ctl(OP_JUMP, ADDR_ARITH_TAIL);
    endtask

    // --------------------
    // ROM contents
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = ctl(OP_HALT, ADDR_HALT);
        end

        // Operand fetch subroutine
        rom[ADDR_OPND_SUB]     = uop(MOP_LOAD_A, 8'd0, ADDR_OPND_SUB + 1);
        rom[ADDR_OPND_SUB + 1] = uop(MOP_LOAD_B, 8'd0, ADDR_OPND_SUB + 2);
        rom[ADDR_OPND_SUB + 2] = ctl(OP_RET, ADDR_HALT);

        // Shared tail for result-producing ops
        rom[ADDR_ARITH_TAIL]     = uop(MOP_LOAD_ARITH_RES, 8'd0, ADDR_ARITH_TAIL + 1);
        rom[ADDR_ARITH_TAIL + 1] = uop(MOP_STORE, 8'd0, ADDR_ARITH_TAIL + 2);
        rom[ADDR_ARITH_TAIL + 2] = ctl(OP_HALT, ADDR_HALT);

        put_arith_prog(ADDR_FADD, AR_ADD);
        put_arith_prog(ADDR_FSUB, AR_SUB);
        put_arith_prog(ADDR_FMUL, AR_MUL);
        put_arith_prog(ADDR_FDIV, AR_DIV);

        // FCOM, merges cc into status word
        rom[ADDR_FCOM]     = ctl(OP_CALL, ADDR_OPND_SUB);
        rom[ADDR_FCOM + 1] = uop(MOP_CALL_ARITH, 8'(AR_CMP), ADDR_FCOM + 2);
        rom[ADDR_FCOM + 2] = uop(MOP_WAIT_ARITH, 8'd0, ADDR_FCOM + 3);
        rom[ADDR_FCOM + 3] = uop(MOP_GET_STATUS, 8'd0, ADDR_FCOM + 4);
        rom[ADDR_FCOM + 4] = uop(MOP_GET_CC, 8'd0, ADDR_FCOM + 5);
        rom[ADDR_FCOM + 5] = uop(MOP_SET_STATUS, 8'd0, ADDR_FCOM + 6);
        rom[ADDR_FCOM + 6] = ctl(OP_HALT, ADDR_HALT);
    end

    always_ff @(posedge clk) begin
        instr <= rom[rom_addr]; // Registered read
    end

    // Entry table
    always_comb begin
        case (entry_idx)
            4'd0:    entry_addr = ADDR_FADD;
            4'd1:    entry_addr = ADDR_FSUB;
            4'd2:    entry_addr = ADDR_FMUL;
            4'd3:    entry_addr = ADDR_FDIV;
            4'd4:    entry_addr = ADDR_FCOM;
            default: entry_addr = ADDR_HALT; // Unused slots halt at once
        endcase
    end

endmodule

//--- hdl/return_stack.sv
`timescale 1ns/1ps

module return_stack
    import fpu_seq_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              clear,     // Program start
    input  logic              push,
    input  logic              pop,
    input  logic [ADDR_W-1:0] push_addr,
    output logic [ADDR_W-1:0] top_addr,  // Combinational read of top
    output logic              empty
);

    logic [ADDR_W-1:0]              mem [STACK_DEPTH];
    logic [$clog2(STACK_DEPTH)-1:0] sp;       // Next free slot, wraps when full
    logic                           empty_q;  // Tells full apart from empty at sp 0

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sp      <= '0;
            empty_q <= 1'b1;
        end else if (clear) begin
            sp      <= '0;
            empty_q <= 1'b1;
        end else if (push) begin
            sp      <= sp + 1'b1;
            empty_q <= 1'b0;
        end else if (pop && !empty_q) begin
            sp      <= sp - 1'b1;
            empty_q <= (sp == 1); // Last entry leaving
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[sp] <= push_addr;
        end
    end

    assign top_addr = mem[sp - 1'b1];
    assign empty    = empty_q;

endmodule

//--- hdl/seq_control.sv
`timescale 1ns/1ps

module seq_control
    import fpu_seq_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [PROG_IDX_W-1:0] prog_index,
    output logic                  done_flag,
    // ROM side
    output logic [ADDR_W-1:0]     rom_addr,
    input  microinstr_t           instr,
    output logic [PROG_IDX_W-1:0] entry_idx,
    input  logic [ADDR_W-1:0]     entry_addr,
    // Return stack side
    output logic                  push,
    output logic                  pop,
    output logic                  clear,
    output logic [ADDR_W-1:0]     push_addr,
    input  logic [ADDR_W-1:0]     top_addr,
    input  logic                  empty,
    // Waits
    input  logic                  arith_done,
    output logic                  data_req,
    output logic                  data_sel,   // 0 = A, 1 = B
    input  logic                  data_valid,
    // To datapath
    output logic                  exec_fire,
    output micro_op_e             exec_op,
    output logic [7:0]            imm_op
);

    seq_state_e        state;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] next_pc;
    logic              arith_seen; // done may pulse while refetching
    logic              in_exec;
    logic              is_load;
    logic              mop_done;   // Micro-op may complete this cycle

    // --------------------
    // Decode helpers
    always_comb begin
        next_pc  = instr.next_addr[ADDR_W-1:0];
        in_exec  = (state == ST_EXEC) && (instr.opcode == OP_EXEC);
        is_load  = (instr.micro_op == MOP_LOAD_A) || (instr.micro_op == MOP_LOAD_B);
        case (instr.micro_op)
            MOP_LOAD_A, MOP_LOAD_B: mop_done = data_valid;
            MOP_WAIT_ARITH:         mop_done = arith_done | arith_seen;
            default:                mop_done = 1'b1;
        endcase
    end

    // Data bus request only in EXEC of a load, answered in the same cycle
    assign data_req  = in_exec && is_load;
    assign data_sel  = (instr.micro_op == MOP_LOAD_B);
    assign exec_fire = in_exec && mop_done;
    assign exec_op   = instr.micro_op;
    assign imm_op    = instr.imm;

    assign rom_addr  = pc;          // ROM sees pc every cycle
    assign entry_idx = prog_index;

    // Return stack controls
    assign clear     = (state == ST_IDLE) && start;
    assign push      = (state == ST_EXEC) && (instr.opcode == OP_CALL);
    assign pop       = (state == ST_EXEC) && (instr.opcode == OP_RET) && !empty;
    assign push_addr = pc + 1'b1;   // Return past the CALL

    // --------------------
    // Main FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            pc        <= ADDR_HALT;
            done_flag <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        pc        <= entry_addr;
                        done_flag <= 1'b0;
                        state     <= ST_FETCH;
                    end
                end
                ST_FETCH:  state <= ST_DECODE; // ROM read in flight
                ST_DECODE: state <= ST_EXEC;
                ST_EXEC: begin
                    state <= ST_FETCH;
                    case (instr.opcode)
                        OP_EXEC: begin
                            if (mop_done) begin
                                pc <= next_pc;
                            end                  // Else refetch same word
                        end
                        OP_JUMP, OP_CALL: pc <= next_pc;
                        OP_RET:  pc <= empty ? ADDR_HALT : top_addr;
                        OP_HALT: begin
                            done_flag <= 1'b1;
                            state     <= ST_IDLE;
                        end
                        default: pc <= next_pc;
                    endcase
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Latch arithmetic done until WAIT_ARITH consumes it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arith_seen <= 1'b0;
        end else if (clear || (exec_fire && instr.micro_op == MOP_WAIT_ARITH)) begin
            arith_seen <= 1'b0;
        end else if (arith_done) begin
            arith_seen <= 1'b1;
        end
    end

endmodule

//--- hdl/seq_datapath.sv
`timescale 1ns/1ps

module seq_datapath
    import fpu_seq_pkg::*;
    import fpu_bus_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                exec_fire,   // Micro-op completes this cycle
    input  micro_op_e           exec_op,
    input  logic [7:0]          imm_op,
    input  fp_word_t            data_in,
    input  arith_rsp_t          arith_rsp,
    output arith_req_t          arith_req,
    output fp_word_t            data_out,
    output logic                data_out_valid,
    input  logic [STATUS_W-1:0] status_in,
    output logic [STATUS_W-1:0] status_out,
    output logic                status_write
);

    // Operand and result registers
    fp_word_t            op_a;
    fp_word_t            op_b;
    fp_word_t            result;
    logic [STATUS_W-1:0] scratch;   // Status word being merged

    // Request payload held for the unit
    arith_op_e           req_op;
    fp_word_t            req_a;
    fp_word_t            req_b;
    logic                req_valid;

    // --------------------
    // One-cycle pulses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_valid      <= 1'b0;
            data_out_valid <= 1'b0;
            status_write   <= 1'b0;
        end else begin
            req_valid      <= exec_fire && (exec_op == MOP_CALL_ARITH);
            data_out_valid <= exec_fire && (exec_op == MOP_STORE);
            status_write   <= exec_fire && (exec_op == MOP_SET_STATUS);
        end
    end

    // --------------------
    // Payload side effects
    always_ff @(posedge clk) begin
        if (exec_fire) begin
            case (exec_op)
                MOP_LOAD_A: op_a <= data_in;
                MOP_LOAD_B: op_b <= data_in;
                MOP_STORE:  data_out <= result;
                MOP_CALL_ARITH: begin
                    req_op <= arith_op_e'(imm_op[4:0]); // Low imm bits name the op
                    req_a  <= op_a;
                    req_b  <= op_b;
                end
                MOP_LOAD_ARITH_RES: result <= arith_rsp.result;
                MOP_GET_STATUS:     scratch <= status_in;
                MOP_GET_CC:         scratch[3:0] <= arith_rsp.cc; // less in bit 0
                MOP_SET_STATUS:     status_out <= scratch;
                default: ;                                       // WAIT_ARITH only waits
            endcase
        end
    end

    always_comb begin
        arith_req.valid = req_valid;
        arith_req.op    = req_op;
        arith_req.a     = req_a;
        arith_req.b     = req_b;
    end

endmodule

//--- hdl/fpu_microseq_top.sv
`timescale 1ns/1ps

module fpu_microseq_top
    import fpu_seq_pkg::*;
    import fpu_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // Control
    input  logic                  start,
    input  logic [PROG_IDX_W-1:0] prog_index,
    output logic                  done_flag,
    // Data bus
    input  fp_word_t              data_in,
    input  logic                  data_valid,
    output logic                  data_req,
    output logic                  data_sel,
    output fp_word_t              data_out,
    output logic                  data_out_valid,
    // Arithmetic unit
    output arith_req_t            arith_req,
    input  arith_rsp_t            arith_rsp,
    // Status word
    input  logic [STATUS_W-1:0]   status_in,
    output logic [STATUS_W-1:0]   status_out,
    output logic                  status_write
);

    // --------------------
    // Internal wiring
    logic [ADDR_W-1:0]     rom_addr;
    microinstr_t           instr;
    logic [PROG_IDX_W-1:0] entry_idx;
    logic [ADDR_W-1:0]     entry_addr;
    logic                  push;
    logic                  pop;
    logic                  clear;
    logic [ADDR_W-1:0]     push_addr;
    logic [ADDR_W-1:0]     top_addr;
    logic                  empty;
    logic                  exec_fire;
    micro_op_e             exec_op;
    logic [7:0]            imm_op;

    micro_rom u_rom (
        .clk        (clk),
        .rom_addr   (rom_addr),
        .instr      (instr),
        .entry_idx  (entry_idx),
        .entry_addr (entry_addr)
    );

    return_stack u_stack (
        .clk       (clk),
        .reset     (reset),
        .clear     (clear),
        .push      (push),
        .pop       (pop),
        .push_addr (push_addr),
        .top_addr  (top_addr),
        .empty     (empty)
    );

    seq_control u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .prog_index (prog_index),
        .done_flag  (done_flag),
        .rom_addr   (rom_addr),
        .instr      (instr),
        .entry_idx  (entry_idx),
        .entry_addr (entry_addr),
        .push       (push),
        .pop        (pop),
        .clear      (clear),
        .push_addr  (push_addr),
        .top_addr   (top_addr),
        .empty      (empty),
        .arith_done (arith_rsp.done), // Only the done bit steers control
        .data_req   (data_req),
        .data_sel   (data_sel),
        .data_valid (data_valid),
        .exec_fire  (exec_fire),
        .exec_op    (exec_op),
        .imm_op     (imm_op)
    );

    seq_datapath u_dp (
        .clk            (clk),
        .reset          (reset),
        .exec_fire      (exec_fire),
        .exec_op        (exec_op),
        .imm_op         (imm_op),
        .data_in        (data_in),
        .arith_rsp      (arith_rsp),
        .arith_req      (arith_req),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .status_in      (status_in),
        .status_out     (status_out),
        .status_write   (status_write)
    );

endmodule

//--- test/arith_unit_model.sv
`timescale 1ns/1ps

module arith_unit_model
    import fpu_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  arith_req_t arith_req,
    output arith_rsp_t arith_rsp
);

    // Unsigned integer behavior on the low 64 bits
    initial begin
        logic [63:0] a_lo;
        logic [63:0] b_lo;
        logic [63:0] r;
        arith_op_e   op;
        int          countdown;
        bit          busy;

        arith_rsp = '0;
        busy      = 1'b0;
        countdown = 0;
        forever begin
            @(posedge clk);
            #1;
            arith_rsp.done = 1'b0;                // done is a single-cycle pulse
            if (!reset && !busy && arith_req.valid) begin
                op        = arith_req.op;
                a_lo      = arith_req.a[63:0];
                b_lo      = arith_req.b[63:0];
                countdown = $urandom_range(1, 8); // Random latency
                busy      = 1'b1;
            end else if (busy) begin
                countdown--;
                if (countdown == 0) begin
                    case (op)
                        AR_ADD:  r = a_lo + b_lo;
                        AR_SUB:  r = a_lo - b_lo;
                        AR_MUL:  r = a_lo * b_lo;
                        AR_DIV:  r = (b_lo == 64'd0) ? 64'd0 : a_lo / b_lo;
                        default: r = a_lo;        // CMP passes A through
                    endcase
                    arith_rsp.done   = 1'b1;
                    arith_rsp.result = {16'h0000, r};
                    arith_rsp.cc     = '0;
                    if (op == AR_CMP) begin
                        arith_rsp.cc.less    = (a_lo < b_lo);
                        arith_rsp.cc.equal   = (a_lo == b_lo);
                        arith_rsp.cc.greater = (a_lo > b_lo);
                    end
                    busy = 1'b0;                  // Result and cc stay held
                end
            end
        end
    end

endmodule

//--- test/tb_fpu_microseq.sv
`timescale 1ns/1ps

module tb_fpu_microseq
    import fpu_seq_pkg::*;
    import fpu_bus_pkg::*;
();

    localparam int NUM_CASES    = 13;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = NUM_CASES * 200;

    // One table row
    typedef struct packed {
        logic [PROG_IDX_W-1:0] prog;
        fp_word_t              a;
        fp_word_t              b;
        logic [STATUS_W-1:0]   status;
        fp_word_t              exp_data;   // Arithmetic programs
        logic [STATUS_W-1:0]   exp_status; // FCOM
    } test_case_t;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic [PROG_IDX_W-1:0] prog_index;
    logic                  done_flag;
    fp_word_t              data_in;
    logic                  data_valid;
    logic                  data_req;
    logic                  data_sel;
    fp_word_t              data_out;
    logic                  data_out_valid;
    arith_req_t            arith_req;
    arith_rsp_t            arith_rsp;
    logic [STATUS_W-1:0]   status_in;
    logic [STATUS_W-1:0]   status_out;
    logic                  status_write;

    test_case_t cases [NUM_CASES];
    int         cycles = 0;

    fpu_microseq_top uut (.*);

    arith_unit_model arith_model (
        .clk       (clk),
        .reset     (reset),
        .arith_req (arith_req),
        .arith_rsp (arith_rsp)
    );

    always #2 clk = ~clk; // 4 ns period

    // --------------------
    // Run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Simulation FAILED");
            $fatal(1, "Timeout after %0d cycles, the sequencer never finished", cycles);
        end
    end

    task automatic compare_value(input string name, input logic [79:0] exp,
                                 input logic [79:0] act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    function automatic test_case_t make_case(input logic [3:0] prog, input fp_word_t a,
                                             input fp_word_t b, input logic [15:0] st,
                                             input fp_word_t exp_d, input logic [15:0] exp_s);
        test_case_t c;
        c.prog       = prog;
        c.a          = a;
        c.b          = b;
        c.status     = st;
        c.exp_data   = exp_d;
        c.exp_status = exp_s;
        return c;
    endfunction

    // Arithmetic op each program sends to the unit
    function automatic arith_op_e op_for_prog(input logic [PROG_IDX_W-1:0] prog);
        case (prog)
            4'd0:    return AR_ADD;
            4'd1:    return AR_SUB;
            4'd2:    return AR_MUL;
            4'd3:    return AR_DIV;
            default: return AR_CMP; // FCOM only
        endcase
    endfunction

    // Quiet outputs while idle
    task automatic check_idle();
        compare_value("done_flag", 80'd0, done_flag);
        compare_value("data_req", 80'd0, data_req);
        compare_value("data_out_valid", 80'd0, data_out_valid);
        compare_value("status_write", 80'd0, status_write);
        compare_value("arith_req.valid", 80'd0, arith_req.valid);
    endtask

    // --------------------
    // One program run and its data bus responder
    task automatic run_case(input int n);
        test_case_t c;
        int         loads = 0;
        int         stores = 0;
        int         writes = 0;
        int         calls = 0;
        int         req_cycles = 0;
        int         delay;
        c          = cases[n];
        prog_index = c.prog;
        status_in  = c.status;
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        compare_value("done_flag", 80'd0, done_flag);   // Cleared by the start
        delay = $urandom_range(0, 3);                   // Requests refused before answer
        while (!done_flag) begin
            data_valid = 1'b0;
            if (data_req) begin
                req_cycles++;
                if (delay > 0) begin
                    delay--;
                end else begin
                    compare_value("data_sel", 80'(loads), data_sel); // A before B
                    data_in    = data_sel ? c.b : c.a;
                    data_valid = 1'b1;
                    loads++;
                    delay = $urandom_range(0, 3);
                end
            end
            if (arith_req.valid) begin
                calls++;
                compare_value("arith_req.op", 80'(op_for_prog(c.prog)), 80'(arith_req.op));
                compare_value("arith_req.a", c.a, arith_req.a); // Full 80-bit operands
                compare_value("arith_req.b", c.b, arith_req.b);
            end
            if (data_out_valid) begin
                stores++;
                compare_value("data_out", c.exp_data, data_out);
            end
            if (status_write) begin
                writes++;
                compare_value("status_out", 80'(c.exp_status), status_out);
            end
            @(posedge clk);
            #1;
        end
        data_valid = 1'b0;
        compare_value("load count", (c.prog < 5) ? 80'd2 : 80'd0, 80'(loads));
        compare_value("store count", (c.prog < 4) ? 80'd1 : 80'd0, 80'(stores));
        compare_value("status write count", (c.prog == 4) ? 80'd1 : 80'd0, 80'(writes));
        compare_value("arith call count", (c.prog < 5) ? 80'd1 : 80'd0, 80'(calls));
        if (c.prog >= 5) compare_value("data_req cycles", 80'd0, 80'(req_cycles));
    endtask

    initial begin
        void'($urandom(51437));
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        prog_index = '0;
        data_in    = '0;
        data_valid = 1'b0;
        status_in  = '0;

        // prog, A, B, status_in, expected data_out, expected status_out
        cases[0]  = make_case(4'd0, 80'h1_2345_6789, 80'h1111_1111, 16'h0, 80'h1_3456_789A, 16'h0);
        cases[1]  = make_case(4'd0, {16'hABCD, 64'hFFFF_FFFF_FFFF_FFFF}, 80'd2, 16'h0,
                              80'd1, 16'h0);                           // Wraps with top bits ignored
        cases[2]  = make_case(4'd1, 80'd1000, 80'd24, 16'h0, 80'd976, 16'h0);
        cases[3]  = make_case(4'd1, 80'd5, 80'd7, 16'h0, {16'h0, 64'hFFFF_FFFF_FFFF_FFFE}, 16'h0);
        cases[4]  = make_case(4'd2, 80'h1_0000_0003, 80'h25, 16'h0, 80'h25_0000_006F, 16'h0);
        cases[5]  = make_case(4'd3, 80'd1000, 80'd7, 16'h0, 80'd142, 16'h0);
        cases[6]  = make_case(4'd3, 80'd1234, 80'd0, 16'h0, 80'd0, 16'h0);  // Divide by zero
        cases[7]  = make_case(4'd4, 80'd3, 80'd9, 16'hA5F0, 80'd0, 16'hA5F1);  // Less
        cases[8]  = make_case(4'd4, 80'd9, 80'd9, 16'h3C0F, 80'd0, 16'h3C02);  // Equal
        cases[9]  = make_case(4'd4, 80'd20, 80'd4, 16'hFFFF, 80'd0, 16'hFFF4); // Greater
        cases[10] = make_case(4'd5, 80'd1, 80'd2, 16'h0, 80'd0, 16'h0);
        cases[11] = make_case(4'd9, 80'd1, 80'd2, 16'h0, 80'd0, 16'h0);
        cases[12] = make_case(4'd15, 80'd1, 80'd2, 16'h0, 80'd0, 16'h0);

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_idle();
        end

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- fpu_microseq.f
hdl/fpu_seq_pkg.sv
hdl/fpu_bus_pkg.sv
hdl/micro_rom.sv
hdl/return_stack.sv
hdl/seq_control.sv
hdl/seq_datapath.sv
hdl/fpu_microseq_top.sv
test/arith_unit_model.sv
test/tb_fpu_microseq.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f fpu_microseq.f \
    --top-module tb_fpu_microseq -o sim_fpu_microseq &&
./obj_dir/sim_fpu_microseq || exit 1
